/* hdl/rvCorePkg.sv */
/*
 * Shared widths, opcodes, ALU operations, instruction word views and
 * pipeline structs for the five-stage RV32I core.
 * Compiled first; every RTL module imports what it needs from here.
 */
package rvCorePkg;

	////////////////////
	// Widths and encodings
	////////////////////
	localparam int xlen = 32;
	localparam int regAddrBits = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [regAddrBits-1:0] regAddr_t;

	// addi x0, x0, 0
	localparam word_t nopWord = 32'h0000_0013;

	localparam logic [6:0] opOp     = 7'b0110011;
	localparam logic [6:0] opOpImm  = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opLui    = 7'b0110111;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluSra,
		aluPassB
	} aluOp_e;

	////////////////////
	// Instruction formats
	////////////////////
	typedef struct packed {
		logic [6:0] funct7;
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		regAddr_t   rd;
		logic [6:0] opcode;
	} rType_t;

	typedef struct packed {
		logic [11:0] imm;
		regAddr_t    rs1;
		logic [2:0]  funct3;
		regAddr_t    rd;
		logic [6:0]  opcode;
	} iType_t;

	typedef struct packed {
		logic [6:0] immHi;
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sType_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} bType_t;

	// Also carries the U-type upper immediate in bits 31:12
	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		regAddr_t   rd;
		logic [6:0] opcode;
	} jType_t;

	typedef union packed {
		rType_t rType;
		iType_t iType;
		sType_t sType;
		bType_t bType;
		jType_t jType;
	} instr_u;

	////////////////////
	// Pipeline payloads
	////////////////////
	typedef struct packed {
		word_t    pc;
		regAddr_t rs1;
		regAddr_t rs2;
		regAddr_t rd;
		word_t    rs1Val;
		word_t    rs2Val;
		word_t    imm;
		aluOp_e   aluOp;
		logic     aluSrcImm;
		logic     aluSrcPc;
		logic     memRead;
		logic     memWrite;
		logic     regWrite;
		logic     memToReg;
	} decodedOp_t;

	// Destination of an instruction further down, seen by hazard detection
	typedef struct packed {
		logic     regWrite;
		logic     memRead;
		regAddr_t rd;
	} stageDest_t;

	typedef struct packed {
		logic     enable;
		regAddr_t addr;
		word_t    data;
	} regWrite_t;

endpackage

/* hdl/instrFetch.sv */
/*
 * Fetch stage. Holds the program counter and the fetch/decode register.
 * Both hold on a decode stall; a redirect loads the target and squashes
 * the word already fetched.
 */
`timescale 1ns/10ps

module instrFetch (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  logic             redirect,
	input  rvCorePkg::word_t target,
	input  rvCorePkg::word_t instrData,
	output rvCorePkg::word_t pc,
	output rvCorePkg::word_t fetchPc,
	output rvCorePkg::word_t fetchInstr
);
	import rvCorePkg::*;

	// Program counter
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= target;
		end else if (!stall) begin
			pc <= pc + word_t'(4);
		end
	end

	// Fetch/decode register
	always_ff @(posedge clk) begin
		if (reset) begin
			fetchPc    <= '0;
			fetchInstr <= nopWord;
		end else if (redirect) begin
			// Wrong-path word becomes a nop
			fetchPc    <= pc;
			fetchInstr <= nopWord;
		end else if (!stall) begin
			fetchPc    <= pc;
			fetchInstr <= instrData;
		end
	end

endmodule

/* hdl/instrDecode.sv */
/*
 * Decode stage, purely combinational. Builds the decoded operation,
 * resolves beq, bne and jal against the register file outputs and
 * raises stall for load-use and branch source hazards.
 */
`timescale 1ns/10ps

module instrDecode (
	input  rvCorePkg::word_t      fetchPc,
	input  rvCorePkg::word_t      fetchInstr,
	input  rvCorePkg::word_t      rd1,
	input  rvCorePkg::word_t      rd2,
	input  rvCorePkg::stageDest_t execDest,
	input  rvCorePkg::stageDest_t memDest,
	output rvCorePkg::regAddr_t   rs1,
	output rvCorePkg::regAddr_t   rs2,
	output rvCorePkg::decodedOp_t decoded,
	output logic                  stall,
	output logic                  redirect,
	output rvCorePkg::word_t      target
);
	import rvCorePkg::*;

	instr_u instr;
	word_t  immI;
	word_t  immS;
	word_t  immB;
	word_t  immJ;
	word_t  immU;
	logic   isBranch;
	logic   isJal;
	logic   usesRs1;
	logic   usesRs2;
	logic   branchTaken;
	logic   loadUse;
	logic   branchHazard;

	function automatic aluOp_e aluFromFunct(logic [2:0] funct3, logic alt, logic allowSub);
		aluOp_e op;
		case (funct3)
			3'b000:  op = (alt && allowSub) ? aluSub : aluAdd;
			3'b001:  op = aluSll;
			3'b010:  op = aluSlt;
			3'b100:  op = aluXor;
			3'b101:  op = alt ? aluSra : aluSrl;
			3'b110:  op = aluOr;
			3'b111:  op = aluAnd;
			default: op = aluAdd;
		endcase
		return op;
	endfunction

	// True when a stage further down will write register r
	function automatic logic writesReg(stageDest_t dest, regAddr_t r);
		return dest.regWrite && dest.rd != '0 && dest.rd == r;
	endfunction

	assign instr = fetchInstr;
	assign rs1   = instr.rType.rs1;
	assign rs2   = instr.rType.rs2;

	////////////////////
	// Immediates
	////////////////////
	assign immI = {{(xlen-12){instr.iType.imm[11]}}, instr.iType.imm};
	assign immS = {{(xlen-12){instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
	assign immB = {{(xlen-12){instr.bType.imm12}}, instr.bType.imm11,
		instr.bType.imm10_5, instr.bType.imm4_1, 1'b0};
	assign immJ = {{(xlen-20){instr.jType.imm20}}, instr.jType.imm19_12,
		instr.jType.imm11, instr.jType.imm10_1, 1'b0};
	// lui upper bits, read in place through the J view
	assign immU = {instr.jType.imm20, instr.jType.imm10_1, instr.jType.imm11,
		instr.jType.imm19_12, 12'b0};

	////////////////////
	// Control decode
	////////////////////
	always_comb begin
		decoded        = '0;
		decoded.pc     = fetchPc;
		decoded.rd     = instr.rType.rd;
		decoded.rs1Val = rd1;
		decoded.rs2Val = rd2;
		decoded.aluOp  = aluAdd;
		isBranch = 1'b0;
		isJal    = 1'b0;
		usesRs1  = 1'b0;
		usesRs2  = 1'b0;
		case (instr.rType.opcode)
			opOp: begin
				decoded.aluOp    = aluFromFunct(instr.rType.funct3, instr.rType.funct7[5], 1'b1);
				decoded.regWrite = 1'b1;
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
			end
			opOpImm: begin
				decoded.aluOp     = aluFromFunct(instr.iType.funct3, instr.rType.funct7[5], 1'b0);
				decoded.imm       = immI;
				decoded.aluSrcImm = 1'b1;
				decoded.regWrite  = 1'b1;
				usesRs1 = 1'b1;
			end
			opLoad: begin
				decoded.imm       = immI;
				decoded.aluSrcImm = 1'b1;
				decoded.memRead   = 1'b1;
				decoded.regWrite  = 1'b1;
				decoded.memToReg  = 1'b1;
				usesRs1 = 1'b1;
			end
			opStore: begin
				decoded.imm       = immS;
				decoded.aluSrcImm = 1'b1;
				decoded.memWrite  = 1'b1;
				usesRs1 = 1'b1;
				usesRs2 = 1'b1;
			end
			opLui: begin
				decoded.aluOp     = aluPassB;
				decoded.imm       = immU;
				decoded.aluSrcImm = 1'b1;
				decoded.regWrite  = 1'b1;
			end
			opJal: begin
				// Link value is pc + 4, computed in execute
				decoded.imm       = word_t'(4);
				decoded.aluSrcImm = 1'b1;
				decoded.aluSrcPc  = 1'b1;
				decoded.regWrite  = 1'b1;
				isJal = 1'b1;
			end
			opBranch: begin
				isBranch = 1'b1;
				usesRs1  = 1'b1;
				usesRs2  = 1'b1;
			end
			default: begin
			end
		endcase
		decoded.rs1 = usesRs1 ? rs1 : '0;
		decoded.rs2 = usesRs2 ? rs2 : '0;
	end

	////////////////////
	// Branches and hazards
	////////////////////
	assign branchTaken = isBranch &&
		((instr.bType.funct3 == 3'b000 && rd1 == rd2) ||
		 (instr.bType.funct3 == 3'b001 && rd1 != rd2));

	assign loadUse = execDest.memRead &&
		((usesRs1 && writesReg(execDest, rs1)) || (usesRs2 && writesReg(execDest, rs2)));

	// Compare needs final values; only writeback reaches the register file in time
	assign branchHazard = isBranch &&
		(writesReg(execDest, rs1) || writesReg(execDest, rs2) ||
		 writesReg(memDest, rs1) || writesReg(memDest, rs2));

	assign stall    = loadUse || branchHazard;
	assign redirect = (isJal || branchTaken) && !stall;
	assign target   = fetchPc + (isJal ? immJ : immB);

endmodule

/* hdl/regFile.sv */
/*
 * 32-entry integer register file. x0 reads as zero, writes land on the
 * clock edge and a read of the register being written sees the new value.
 */
`timescale 1ns/10ps

module regFile (
	input  logic                 clk,
	input  logic                 reset,
	input  rvCorePkg::regAddr_t  rs1,
	input  rvCorePkg::regAddr_t  rs2,
	input  rvCorePkg::regWrite_t write,
	output rvCorePkg::word_t     rd1,
	output rvCorePkg::word_t     rd2
);
	import rvCorePkg::*;

	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write.enable && write.addr != '0) begin
			regs[write.addr] <= write.data;
		end
	end

	// Write-through from writeback
	assign rd1 = (rs1 == '0) ? '0 :
		(write.enable && write.addr == rs1) ? write.data : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 :
		(write.enable && write.addr == rs2) ? write.data : regs[rs2];

endmodule

/* hdl/decodeExecReg.sv */
/*
 * Decode/execute pipeline register. Takes the decoded operation every
 * cycle and turns it into a bubble while decode is stalled.
 */
`timescale 1ns/10ps

module decodeExecReg (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  stall,
	input  rvCorePkg::decodedOp_t decoded,
	output rvCorePkg::decodedOp_t execOp,
	output rvCorePkg::stageDest_t execDest
);

	always_ff @(posedge clk) begin
		execOp <= decoded;
		if (reset || stall) begin
			// Bubble keeps the payload but loses all side effects
			execOp.regWrite <= 1'b0;
			execOp.memRead  <= 1'b0;
			execOp.memWrite <= 1'b0;
			execOp.memToReg <= 1'b0;
		end
	end

	// Seen by decode for load-use and branch hazards
	assign execDest.regWrite = execOp.regWrite;
	assign execDest.memRead  = execOp.memRead;
	assign execDest.rd       = execOp.rd;

endmodule

/* hdl/executeUnit.sv */
/*
 * Back end of the core: operand forwarding, the ALU, the execute/memory
 * and memory/writeback registers and the writeback select. The memory
 * strobes and address come straight from the execute/memory register.
 */
`timescale 1ns/10ps

module executeUnit (
	input  logic                  clk,
	input  logic                  reset,
	input  rvCorePkg::decodedOp_t execOp,
	input  rvCorePkg::word_t      memData,
	output rvCorePkg::stageDest_t memDest,
	output rvCorePkg::regWrite_t  write,
	output logic                  memRead,
	output logic                  memWrite,
	output rvCorePkg::word_t      rwAddress,
	output rvCorePkg::word_t      writeData
);
	import rvCorePkg::*;

	typedef struct packed {
		logic     regWrite;
		logic     memRead;
		logic     memWrite;
		logic     memToReg;
		regAddr_t rd;
		word_t    aluOut;
		word_t    storeData;
	} memStage_t;

	typedef struct packed {
		logic     regWrite;
		logic     memToReg;
		regAddr_t rd;
		word_t    aluOut;
		word_t    loadData;
	} wbStage_t;

	memStage_t memStage;
	wbStage_t  wbStage;
	word_t     opA;
	word_t     opB;
	word_t     srcA;
	word_t     srcB;
	word_t     aluOut;
	word_t     wbData;

	// Memory stage has priority, being the younger result
	function automatic word_t forwardValue(regAddr_t rs, word_t regVal, memStage_t m,
		regWrite_t w);
		word_t value;
		if (rs != '0 && m.regWrite && m.rd == rs) begin
			value = m.aluOut;
		end else if (rs != '0 && w.enable && w.addr == rs) begin
			value = w.data;
		end else begin
			value = regVal;
		end
		return value;
	endfunction

	////////////////////
	// Execute
	////////////////////
	assign opA  = forwardValue(execOp.rs1, execOp.rs1Val, memStage, write);
	assign opB  = forwardValue(execOp.rs2, execOp.rs2Val, memStage, write);
	assign srcA = execOp.aluSrcPc ? execOp.pc : opA;
	assign srcB = execOp.aluSrcImm ? execOp.imm : opB;

	always_comb begin
		case (execOp.aluOp)
			aluAdd:   aluOut = srcA + srcB;
			aluSub:   aluOut = srcA - srcB;
			aluAnd:   aluOut = srcA & srcB;
			aluOr:    aluOut = srcA | srcB;
			aluXor:   aluOut = srcA ^ srcB;
			aluSlt:   aluOut = {{(xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			aluSll:   aluOut = srcA << srcB[4:0];
			aluSrl:   aluOut = srcA >> srcB[4:0];
			aluSra:   aluOut = $signed(srcA) >>> srcB[4:0];
			aluPassB: aluOut = srcB;
			default:  aluOut = srcA + srcB;
		endcase
	end

	////////////////////
	// Pipeline registers
	////////////////////
	always_ff @(posedge clk) begin
		memStage.rd        <= execOp.rd;
		memStage.aluOut    <= aluOut;
		memStage.storeData <= opB;
		wbStage.rd         <= memStage.rd;
		wbStage.aluOut     <= memStage.aluOut;
		// Memory read data is valid in the same cycle as the address
		wbStage.loadData   <= memData;
		if (reset) begin
			memStage.regWrite <= 1'b0;
			memStage.memRead  <= 1'b0;
			memStage.memWrite <= 1'b0;
			memStage.memToReg <= 1'b0;
			wbStage.regWrite  <= 1'b0;
			wbStage.memToReg  <= 1'b0;
		end else begin
			memStage.regWrite <= execOp.regWrite;
			memStage.memRead  <= execOp.memRead;
			memStage.memWrite <= execOp.memWrite;
			memStage.memToReg <= execOp.memToReg;
			wbStage.regWrite  <= memStage.regWrite;
			wbStage.memToReg  <= memStage.memToReg;
		end
	end

	// Memory port
	assign memRead   = memStage.memRead;
	assign memWrite  = memStage.memWrite;
	assign rwAddress = memStage.aluOut;
	assign writeData = memStage.storeData;

	assign memDest.regWrite = memStage.regWrite;
	assign memDest.memRead  = memStage.memRead;
	assign memDest.rd       = memStage.rd;

	// Writeback
	assign wbData       = wbStage.memToReg ? wbStage.loadData : wbStage.aluOut;
	assign write.enable = wbStage.regWrite;
	assign write.addr   = wbStage.rd;
	assign write.data   = wbData;

endmodule

/* hdl/rvCore.sv */
/*
 * Top of the five-stage RV32I core. Connects fetch, decode, the register
 * file, the decode/execute register and the back end to the instruction
 * and data memory ports.
 */
`timescale 1ns/10ps

module rvCore (
	input  logic             clk,
	input  logic             reset,
	input  rvCorePkg::word_t instrData,
	input  rvCorePkg::word_t memData,
	output rvCorePkg::word_t pc,
	output logic             memRead,
	output logic             memWrite,
	output rvCorePkg::word_t rwAddress,
	output rvCorePkg::word_t writeData
);
	import rvCorePkg::*;

	word_t      fetchPc;
	word_t      fetchInstr;
	word_t      target;
	word_t      rd1;
	word_t      rd2;
	regAddr_t   rs1;
	regAddr_t   rs2;
	decodedOp_t decoded;
	decodedOp_t execOp;
	stageDest_t execDest;
	stageDest_t memDest;
	regWrite_t  wbWrite;
	logic       stall;
	logic       redirect;

	////////////////////
	// Front end
	////////////////////
	instrFetch fetchStage (
		.clk        (clk),
		.reset      (reset),
		.stall      (stall),
		.redirect   (redirect),
		.target     (target),
		.instrData  (instrData),
		.pc         (pc),
		.fetchPc    (fetchPc),
		.fetchInstr (fetchInstr)
	);

	instrDecode decodeStage (
		.fetchPc    (fetchPc),
		.fetchInstr (fetchInstr),
		.rd1        (rd1),
		.rd2        (rd2),
		.execDest   (execDest),
		.memDest    (memDest),
		.rs1        (rs1),
		.rs2        (rs2),
		.decoded    (decoded),
		.stall      (stall),
		.redirect   (redirect),
		.target     (target)
	);

	regFile registers (
		.clk   (clk),
		.reset (reset),
		.rs1   (rs1),
		.rs2   (rs2),
		.write (wbWrite),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	////////////////////
	// Back end
	////////////////////
	decodeExecReg decodeExec (
		.clk      (clk),
		.reset    (reset),
		.stall    (stall),
		.decoded  (decoded),
		.execOp   (execOp),
		.execDest (execDest)
	);

	executeUnit backEnd (
		.clk       (clk),
		.reset     (reset),
		.execOp    (execOp),
		.memData   (memData),
		.memDest   (memDest),
		.write     (wbWrite),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.rwAddress (rwAddress),
		.writeData (writeData)
	);

endmodule

/* dv/rvCoreTbClock.sv */
/*
 * Testbench clock and reset. 10 ns clock; reset is held high for the
 * first five rising edges and released just after the fifth.
 */
`timescale 1ns/10ps

module rvCoreTbClock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

/* dv/rvCoreAssertions.sv */
/*
 * Concurrent checks on the data memory strobes and the decode control
 * of the core. Bound into every rvCore instance at the end of this file.
 */
`timescale 1ns/10ps

module rvCoreAssertions (
	input logic clk,
	input logic reset,
	input logic memRead,
	input logic memWrite,
	input logic stall,
	input logic redirect
);

	// One strobe at a time on the data port
	noReadWithWrite: assert property (@(posedge clk) disable iff (reset)
		!(memRead && memWrite))
		else $error("memRead and memWrite are high together");

	// Memory stage register already cleared one edge into reset
	quietInReset: assert property (@(posedge clk) $past(reset) |-> !memRead && !memWrite)
		else $error("memory strobe high while in reset");

	noRedirectWhileStalled: assert property (@(posedge clk) disable iff (reset)
		!(stall && redirect))
		else $error("stall and redirect are high together");

endmodule

bind rvCore rvCoreAssertions coreChecks (
	.clk      (clk),
	.reset    (reset),
	.memRead  (memRead),
	.memWrite (memWrite),
	.stall    (stall),
	.redirect (redirect)
);

/* dv/rvCoreTb.sv */
/*
 * Testbench for the five-stage RV32I core. Reads the program, initial data
 * and expected stores from dv/programInput.txt, models both memories and
 * checks every store in order and the final self-jump PC.
 */
`timescale 1ns/10ps

module rvCoreTb;
	import rvCorePkg::*;

	localparam int memWords = 256;
	localparam int pcChecks = 4;
	localparam string inputFile = "dv/programInput.txt";

	logic  clk;
	logic  reset;
	word_t instrData;
	word_t memData;
	word_t pc;
	logic  memRead;
	logic  memWrite;
	word_t rwAddress;
	word_t writeData;

	word_t instrMem [memWords];
	word_t dataMem [memWords];
	word_t expAddrQ [$];
	word_t expDataQ [$];
	int    programWords;
	int    expectedStores;
	int    storesSeen;
	int    passCount;
	int    failCount;
	bit    loaded;

	rvCoreTbClock clockGen (
		.clk   (clk),
		.reset (reset)
	);

	rvCore dut (
		.clk       (clk),
		.reset     (reset),
		.instrData (instrData),
		.memData   (memData),
		.pc        (pc),
		.memRead   (memRead),
		.memWrite  (memWrite),
		.rwAddress (rwAddress),
		.writeData (writeData)
	);

	////////////////////
	// Compare tasks
	////////////////////
	task automatic checkStore(input int index, input word_t addr, input word_t data,
		input word_t expAddr, input word_t expData);
		logic ok;
		ok = 1'b1;
		if (addr !== expAddr) begin
			$display("** Error: rwAddress = 0x%08h, expected 0x%08h", addr, expAddr);
			ok = 1'b0;
		end
		if (data !== expData) begin
			$display("** Error: writeData = 0x%08h, expected 0x%08h", data, expData);
			ok = 1'b0;
		end
		if (ok) begin
			passCount++;
			$display("store %0d ok: 0x%08h at 0x%08h", index, data, addr);
		end else begin
			failCount++;
			$display("store %0d failed", index);
		end
	endtask

	task automatic checkPc(input int index, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("** Error: pc = 0x%08h, expected 0x%08h", actual, expected);
			failCount++;
			$display("self-jump pc %0d failed", index);
		end else begin
			passCount++;
			$display("self-jump pc %0d ok: 0x%08h", index, actual);
		end
	endtask

	////////////////////
	// Memories and program file
	////////////////////
	task automatic fillMemories();
		for (int i = 0; i < memWords; i++) begin
			// Spare slots are nops carrying their byte address in the immediate
			instrMem[i[7:0]] = nopWord | (word_t'(i * 4) << 20);
			// Background differs at every address so a stray load shows up
			dataMem[i[7:0]] = 32'h5a5a_0000 ^ word_t'(i * 4);
		end
	endtask

	task automatic loadProgram(output logic ok);
		int         fd;
		int         n;
		string      line;
		string      rest;
		logic [7:0] kind;
		word_t      w0;
		word_t      w1;
		word_t      w2;
		word_t      w3;
		word_t      words [$];
		ok = 1'b0;
		programWords = 0;
		fd = $fopen(inputFile, "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1) begin
					kind = line.getc(0);
					rest = line.substr(1, line.len() - 1);
					case (kind)
						"I": begin
							n = $sscanf(rest, "%h %h %h %h", w0, w1, w2, w3);
							words = {w0, w1, w2, w3};
							for (int k = 0; k < n; k++) begin
								instrMem[programWords[7:0]] = words[k];
								programWords++;
							end
						end
						"M": begin
							n = $sscanf(rest, "%h %h", w0, w1);
							if (n == 2) begin
								dataMem[w0[9:2]] = w1;
							end
						end
						"E": begin
							n = $sscanf(rest, "%h %h", w0, w1);
							if (n == 2) begin
								expAddrQ.push_back(w0);
								expDataQ.push_back(w1);
							end
						end
						default: begin
						end
					endcase
				end
			end
			$fclose(fd);
			expectedStores = expAddrQ.size();
			ok = (programWords > 0) && (expectedStores > 0);
		end
	endtask

	// Both memories answer within the cycle, driven just after the edge.
	// Read data is only valid while the core asks for it
	initial begin
		instrData = nopWord;
		memData   = '0;
		forever begin
			@(posedge clk);
			#1;
			instrData = instrMem[pc[9:2]];
			memData   = memRead ? dataMem[rwAddress[9:2]] : 'x;
		end
	end

	// Stores are checked and written mid-cycle
	always @(negedge clk) begin
		if (!reset && memWrite) begin
			dataMem[rwAddress[9:2]] = writeData;
			if (storesSeen < expectedStores) begin
				checkStore(storesSeen, rwAddress, writeData, expAddrQ[storesSeen],
					expDataQ[storesSeen]);
			end else begin
				$display("unexpected store of 0x%08h to 0x%08h after the last expected one",
					writeData, rwAddress);
				failCount++;
			end
			storesSeen++;
		end
	end

	////////////////////
	// Watchdog
	////////////////////
	initial begin
		wait (loaded);
		repeat (programWords * 8 + 100) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", programWords * 8 + 100);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic  loadOk;
		logic  found;
		word_t jumpAddr;
		word_t expPc;
		fillMemories();
		loadProgram(loadOk);
		if (!loadOk) begin
			$display("could not read program words and expected stores from %s", inputFile);
			$display("*** FAILED ***");
			$finish;
		end else begin
			loaded = 1'b1;
			wait (storesSeen >= expectedStores);
			// Last program word is the self-jump
			jumpAddr = word_t'((programWords - 1) * 4);
			found = 1'b0;
			for (int i = 0; i < 4 && !found; i++) begin
				@(negedge clk);
				found = (pc == jumpAddr);
			end
			if (!found) begin
				$display("pc did not reach the self-jump at 0x%08h", jumpAddr);
				failCount++;
			end else begin
				for (int i = 0; i < pcChecks; i++) begin
					@(negedge clk);
					// Jump in decode with the next word fetched, then the squashed slot
					expPc = (i % 2 == 0) ? jumpAddr + word_t'(4) : jumpAddr;
					checkPc(i, pc, expPc);
				end
			end
			$display("%0d checks passed, %0d failed", passCount, failCount);
			if (failCount == 0) begin
				$display("*** PASSED ***");
			end else begin
				$display("*** FAILED ***");
			end
			$finish;
		end
	end

endmodule

/* dv/programInput.txt */
# I: up to four instruction words, loaded in order from address 0
# M: data byte address and word; E: expected store address and data, in store order
I 20000513 00700093 ffd00113 002081b3  # 00: x10 = 0x200, x1 = 7, x2 = -3, add
I 00352023 40208233 00452223 0020f2b3  # 10: sw, sub, sw, and
I 0020e333 0062c3b3 00552423 00652623  # 20: or, xor, sw, sw
I 00752823 00112433 008094b3 00852a23  # 30: sw, slt, sll, sw
I 00952c23 008155b3 40815633 00b52e23  # 40: sw, srl, sra, sw
I 02c52023 123456b7 6786e693 0ff6f713  # 50: sw, lui, ori, andi
I fff74793 0007a813 02d52223 02f52423  # 60: xori, slti, sw, sw
I 03052623 10002883 00188933 03252823  # 70: sw, lw, add on the load, sw
I 00208463 02152a23 00209463 02252c23  # 80: beq not taken, sw, bne taken, skipped sw
I 00008993 00198463 02252e23 00109463  # 90: addi, beq taken on it, skipped sw, bne
I 05352023 00800a6f 04252223 05452223  # a0: sw, jal x20, skipped sw, sw link
I 0000006f                             # b0: self-jump
M 00000100 11110000
E 00000200 00000004  # add
E 00000204 0000000a  # sub
E 00000208 00000005  # and
E 0000020c ffffffff  # or
E 00000210 fffffffa  # xor
E 00000214 00000001  # slt
E 00000218 0000000e  # sll
E 0000021c 7ffffffe  # srl
E 00000220 fffffffe  # sra
E 00000224 12345678  # lui and ori
E 00000228 ffffff87  # andi and xori
E 0000022c 00000001  # slti
E 00000230 11110007  # lw then add
E 00000234 00000007  # after beq not taken
E 00000240 00000007  # after beq taken and bne not taken
E 00000244 000000a8  # jal link

/* verilog.f */
hdl/rvCorePkg.sv
hdl/instrFetch.sv
hdl/instrDecode.sv
hdl/regFile.sv
hdl/decodeExecReg.sv
hdl/executeUnit.sv
hdl/rvCore.sv
dv/rvCoreTbClock.sv
dv/rvCoreAssertions.sv
dv/rvCoreTb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := rvCoreTb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := *** FAILED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
